//--- filelist.f
+incdir+include
hdl/axi_mem_pkg.sv
hdl/req_fifo.sv
hdl/burst_addr_gen.sv
hdl/byte_ram.sv
hdl/axi_burst_ctrl.sv
hdl/axi4_mem_slave.sv
verification/tb_axi4_mem_slave.sv

//--- Makefile
TOP := tb_axi4_mem_slave

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/tb_axi4_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_cfg.svh"

module tb_axi4_mem_slave;

	localparam int MEM_WORDS = 1 << `MEM_ADDR_WIDTH;
	localparam int STRB_W    = `AXI_STRB_WIDTH;

	// one row of the stimulus table
	typedef struct packed {
		logic                       is_read;
		logic [`AXI_ID_WIDTH-1:0]   id;
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [`AXI_LEN_WIDTH-1:0]  len;
		logic [2:0]                 size;
		logic [`AXI_STRB_WIDTH-1:0] strb;
		logic                       stall;
	} op_t;

	logic aclk = 1'b0;
	logic aresetn;

	logic [`AXI_ID_WIDTH-1:0]   s_axi4_awid;
	logic [`AXI_ADDR_WIDTH-1:0] s_axi4_awaddr;
	logic [`AXI_LEN_WIDTH-1:0]  s_axi4_awlen;
	logic [2:0]                 s_axi4_awsize;
	logic                       s_axi4_awvalid;
	logic                       s_axi4_awready;
	logic [`AXI_DATA_WIDTH-1:0] s_axi4_wdata;
	logic [`AXI_STRB_WIDTH-1:0] s_axi4_wstrb;
	logic                       s_axi4_wlast;
	logic                       s_axi4_wvalid;
	logic                       s_axi4_wready;
	logic [`AXI_ID_WIDTH-1:0]   s_axi4_bid;
	logic [1:0]                 s_axi4_bresp;
	logic                       s_axi4_bvalid;
	logic                       s_axi4_bready;
	logic [`AXI_ID_WIDTH-1:0]   s_axi4_arid;
	logic [`AXI_ADDR_WIDTH-1:0] s_axi4_araddr;
	logic [`AXI_LEN_WIDTH-1:0]  s_axi4_arlen;
	logic [2:0]                 s_axi4_arsize;
	logic                       s_axi4_arvalid;
	logic                       s_axi4_arready;
	logic [`AXI_ID_WIDTH-1:0]   s_axi4_rid;
	logic [`AXI_DATA_WIDTH-1:0] s_axi4_rdata;
	logic [1:0]                 s_axi4_rresp;
	logic                       s_axi4_rlast;
	logic                       s_axi4_rvalid;
	logic                       s_axi4_rready;

	op_t        ops [$];
	logic [7:0] shadow [MEM_WORDS * STRB_W];
	integer     seed;
	int         cycles = 0;
	int         cycle_limit = 0;
	int         b_seen = 0;
	int         r_seen = 0;
	int         exp_b = 0;
	int         exp_r = 0;
	int         total_beats = 0;

	always #20 aclk = ~aclk;

	axi4_mem_slave dut_i (
		.aclk           (aclk),
		.aresetn        (aresetn),
		.s_axi4_awid    (s_axi4_awid),
		.s_axi4_awaddr  (s_axi4_awaddr),
		.s_axi4_awlen   (s_axi4_awlen),
		.s_axi4_awsize  (s_axi4_awsize),
		.s_axi4_awburst (2'b01),
		.s_axi4_awlock  (1'b0),
		.s_axi4_awcache (4'h0),
		.s_axi4_awprot  (3'h0),
		.s_axi4_awqos   (4'h0),
		.s_axi4_awvalid (s_axi4_awvalid),
		.s_axi4_awready (s_axi4_awready),
		.s_axi4_wdata   (s_axi4_wdata),
		.s_axi4_wstrb   (s_axi4_wstrb),
		.s_axi4_wlast   (s_axi4_wlast),
		.s_axi4_wvalid  (s_axi4_wvalid),
		.s_axi4_wready  (s_axi4_wready),
		.s_axi4_bid     (s_axi4_bid),
		.s_axi4_bresp   (s_axi4_bresp),
		.s_axi4_bvalid  (s_axi4_bvalid),
		.s_axi4_bready  (s_axi4_bready),
		.s_axi4_arid    (s_axi4_arid),
		.s_axi4_araddr  (s_axi4_araddr),
		.s_axi4_arlen   (s_axi4_arlen),
		.s_axi4_arsize  (s_axi4_arsize),
		.s_axi4_arburst (2'b01),
		.s_axi4_arlock  (1'b0),
		.s_axi4_arcache (4'h0),
		.s_axi4_arprot  (3'h0),
		.s_axi4_arqos   (4'h0),
		.s_axi4_arvalid (s_axi4_arvalid),
		.s_axi4_arready (s_axi4_arready),
		.s_axi4_rid     (s_axi4_rid),
		.s_axi4_rdata   (s_axi4_rdata),
		.s_axi4_rresp   (s_axi4_rresp),
		.s_axi4_rlast   (s_axi4_rlast),
		.s_axi4_rvalid  (s_axi4_rvalid),
		.s_axi4_rready  (s_axi4_rready)
	);

	// --------------------
	// helpers
	// --------------------

	task automatic add_op(input logic rd, input int id, input logic [31:0] addr,
		input int len, input int size, input logic [3:0] strb, input logic stall);
		op_t op;
		op.is_read = rd;
		op.id      = id[`AXI_ID_WIDTH-1:0];
		op.addr    = addr;
		op.len     = len[`AXI_LEN_WIDTH-1:0];
		op.size    = size[2:0];
		op.strb    = strb;
		op.stall   = stall;
		ops.push_back(op);
	endtask

	task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("** Error at time %0t: %s is 0x%08h, expected 0x%08h",
				$time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	// byte lanes a narrow beat may touch at this address
	function automatic logic [`AXI_STRB_WIDTH-1:0] lane_mask(input logic [31:0] addr,
		input logic [2:0] size);
		int nbytes;
		int first;
		nbytes = 1 << size;
		if (nbytes >= STRB_W) begin
			return '1;
		end
		first = int'(addr % STRB_W) / nbytes * nbytes;
		return STRB_W'(((1 << nbytes) - 1) << first);
	endfunction

	// word index wraps modulo the memory depth
	function automatic int word_of(input logic [31:0] addr);
		return int'((addr >> `AXI_DATA_SIZE) % MEM_WORDS);
	endfunction

	function automatic logic [31:0] shadow_word(input int idx);
		logic [31:0] w;
		for (int i = 0; i < STRB_W; i++) begin
			w[i*8 +: 8] = shadow[idx*STRB_W + i];
		end
		return w;
	endfunction

	task automatic write_burst(input op_t op);
		logic [31:0] addr;
		logic [3:0]  strb;
		logic [31:0] data;
		int          idx;
		s_axi4_awid    <= op.id;
		s_axi4_awaddr  <= op.addr;
		s_axi4_awlen   <= op.len;
		s_axi4_awsize  <= op.size;
		s_axi4_awvalid <= 1'b1;
		@(posedge aclk);
		while (!s_axi4_awready) @(posedge aclk);
		s_axi4_awvalid <= 1'b0;
		for (int b = 0; b <= int'(op.len); b++) begin
			addr = op.addr + (32'(b) << op.size);
			strb = op.strb & lane_mask(addr, op.size);
			data = $random(seed);
			s_axi4_wdata  <= data;
			s_axi4_wstrb  <= strb;
			s_axi4_wlast  <= (b == int'(op.len));
			s_axi4_wvalid <= 1'b1;
			@(posedge aclk);
			while (!s_axi4_wready) @(posedge aclk);
			// shadow takes only the strobed bytes
			idx = word_of(addr);
			for (int i = 0; i < STRB_W; i++) begin
				if (strb[i]) begin
					shadow[idx*STRB_W + i] = data[i*8 +: 8];
				end
			end
		end
		s_axi4_wvalid <= 1'b0;
		s_axi4_wlast  <= 1'b0;
		@(posedge aclk);
		while (!s_axi4_bvalid) @(posedge aclk);
		compare_value(32'(s_axi4_bid), 32'(op.id), "bid");
		compare_value(32'(s_axi4_bresp), 32'd0, "bresp");
	endtask

	task automatic read_burst(input op_t op);
		logic [31:0] addr;
		int          beat;
		s_axi4_arid    <= op.id;
		s_axi4_araddr  <= op.addr;
		s_axi4_arlen   <= op.len;
		s_axi4_arsize  <= op.size;
		s_axi4_arvalid <= 1'b1;
		@(posedge aclk);
		while (!s_axi4_arready) @(posedge aclk);
		s_axi4_arvalid <= 1'b0;
		beat = 0;
		while (beat <= int'(op.len)) begin
			if (op.stall) begin
				s_axi4_rready <= 1'($random(seed));
			end else begin
				s_axi4_rready <= 1'b1;
			end
			@(posedge aclk);
			if (s_axi4_rvalid && s_axi4_rready) begin
				addr = op.addr + (32'(beat) << op.size);
				compare_value(s_axi4_rdata, shadow_word(word_of(addr)), "rdata");
				compare_value(32'(s_axi4_rid), 32'(op.id), "rid");
				compare_value(32'(s_axi4_rresp), 32'd0, "rresp");
				compare_value(32'(s_axi4_rlast), 32'(beat == int'(op.len)), "rlast");
				beat++;
			end
		end
		s_axi4_rready <= 1'b1;
	endtask

	// counts handshakes and bounds the run
	always @(posedge aclk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
			$display("Simulation FAILED");
			$fatal(1);
		end
		if (aresetn) begin
			if (s_axi4_bvalid && s_axi4_bready) begin
				b_seen++;
			end
			if (s_axi4_rvalid && s_axi4_rready) begin
				r_seen++;
			end
		end
	end

	// --------------------
	// main sequence
	// --------------------

	initial begin
		seed = 6639;
		aresetn        <= 1'b0;
		s_axi4_awid    <= '0;
		s_axi4_awaddr  <= '0;
		s_axi4_awlen   <= '0;
		s_axi4_awsize  <= '0;
		s_axi4_awvalid <= 1'b0;
		s_axi4_wdata   <= '0;
		s_axi4_wstrb   <= '0;
		s_axi4_wlast   <= 1'b0;
		s_axi4_wvalid  <= 1'b0;
		s_axi4_bready  <= 1'b0;
		s_axi4_arid    <= '0;
		s_axi4_araddr  <= '0;
		s_axi4_arlen   <= '0;
		s_axi4_arsize  <= '0;
		s_axi4_arvalid <= 1'b0;
		s_axi4_rready  <= 1'b0;

		//     rd id  addr          len size strb  stall
		add_op(0, 1,  32'h0000_0100, 0,  2, 4'hF, 0);
		add_op(1, 2,  32'h0000_0100, 0,  2, 4'hF, 0);
		add_op(0, 3,  32'h0000_0200, 3,  2, 4'hF, 0);
		add_op(1, 4,  32'h0000_0200, 3,  2, 4'hF, 0);
		add_op(0, 5,  32'h0000_0400, 15, 2, 4'hF, 0);
		add_op(1, 6,  32'h0000_0400, 15, 2, 4'hF, 0);
		// partial strobes, byte and halfword beats over written words
		add_op(0, 7,  32'h0000_0204, 1,  2, 4'h5, 0);
		add_op(0, 8,  32'h0000_0201, 2,  0, 4'hF, 0);
		add_op(0, 9,  32'h0000_040C, 1,  1, 4'hF, 0);
		add_op(0, 10, 32'h0000_0410, 3,  0, 4'h6, 0);
		add_op(1, 11, 32'h0000_0200, 3,  2, 4'hF, 0);
		add_op(1, 12, 32'h0000_0400, 15, 2, 4'hF, 1);
		add_op(1, 13, 32'h0000_0202, 3,  1, 4'hF, 1);
		// past the top of the memory, then an aliased high address
		add_op(0, 14, 32'h0000_0FF0, 5,  2, 4'hF, 0);
		add_op(1, 15, 32'h0000_0FF0, 5,  2, 4'hF, 1);
		add_op(0, 0,  32'h0001_0008, 0,  2, 4'hF, 0);
		add_op(1, 1,  32'h0000_0000, 2,  2, 4'hF, 1);
		add_op(1, 2,  32'h0000_0100, 0,  2, 4'hF, 1);

		foreach (ops[i]) begin
			total_beats += int'(ops[i].len) + 1;
			if (ops[i].is_read) begin
				exp_r += int'(ops[i].len) + 1;
			end else begin
				exp_b++;
			end
		end
		cycle_limit = 20 * total_beats + 200;

		repeat (8) @(posedge aclk);
		aresetn       <= 1'b1;
		s_axi4_bready <= 1'b1;
		s_axi4_rready <= 1'b1;
		@(posedge aclk);

		foreach (ops[i]) begin
			if (ops[i].is_read) begin
				read_burst(ops[i]);
			end else begin
				write_burst(ops[i]);
			end
		end

		// let stray responses show up in the counters
		repeat (10) @(posedge aclk);
		compare_value(32'(b_seen), 32'(exp_b), "write response count");
		compare_value(32'(r_seen), 32'(exp_r), "read beat count");
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/axi4_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_cfg.svh"

module axi4_mem_slave (
	input  logic                       aclk,
	input  logic                       aresetn,

	input  logic [`AXI_ID_WIDTH-1:0]   s_axi4_awid,
	input  logic [`AXI_ADDR_WIDTH-1:0] s_axi4_awaddr,
	input  logic [`AXI_LEN_WIDTH-1:0]  s_axi4_awlen,
	input  logic [2:0]                 s_axi4_awsize,
	input  logic [1:0]                 s_axi4_awburst,
	input  logic [0:0]                 s_axi4_awlock,
	input  logic [3:0]                 s_axi4_awcache,
	input  logic [2:0]                 s_axi4_awprot,
	input  logic [3:0]                 s_axi4_awqos,
	input  logic                       s_axi4_awvalid,
	output logic                       s_axi4_awready,

	input  logic [`AXI_DATA_WIDTH-1:0] s_axi4_wdata,
	input  logic [`AXI_STRB_WIDTH-1:0] s_axi4_wstrb,
	input  logic                       s_axi4_wlast,
	input  logic                       s_axi4_wvalid,
	output logic                       s_axi4_wready,

	output logic [`AXI_ID_WIDTH-1:0]   s_axi4_bid,
	output logic [1:0]                 s_axi4_bresp,
	output logic                       s_axi4_bvalid,
	input  logic                       s_axi4_bready,

	input  logic [`AXI_ID_WIDTH-1:0]   s_axi4_arid,
	input  logic [`AXI_ADDR_WIDTH-1:0] s_axi4_araddr,
	input  logic [`AXI_LEN_WIDTH-1:0]  s_axi4_arlen,
	input  logic [2:0]                 s_axi4_arsize,
	input  logic [1:0]                 s_axi4_arburst,
	input  logic [0:0]                 s_axi4_arlock,
	input  logic [3:0]                 s_axi4_arcache,
	input  logic [2:0]                 s_axi4_arprot,
	input  logic [3:0]                 s_axi4_arqos,
	input  logic                       s_axi4_arvalid,
	output logic                       s_axi4_arready,

	output logic [`AXI_ID_WIDTH-1:0]   s_axi4_rid,
	output logic [`AXI_DATA_WIDTH-1:0] s_axi4_rdata,
	output logic [1:0]                 s_axi4_rresp,
	output logic                       s_axi4_rlast,
	output logic                       s_axi4_rvalid,
	input  logic                       s_axi4_rready
);

	// burst, lock, cache, prot and qos take no part, everything is incr

	axi_mem_pkg::axi_req_t aw_in;
	axi_mem_pkg::axi_req_t aw_req;
	axi_mem_pkg::axi_req_t ar_in;
	axi_mem_pkg::axi_req_t ar_req;
	axi_mem_pkg::w_beat_t  w_beat;
	axi_mem_pkg::r_beat_t  r_beat;

	logic aw_req_valid;
	logic aw_req_ready;
	logic ar_req_valid;
	logic ar_req_ready;

	logic wr_load;
	logic wr_step;
	logic wr_last;
	logic rd_load;
	logic rd_step;
	logic rd_last;

	logic [`MEM_ADDR_WIDTH-1:0] wr_index;
	logic [`MEM_ADDR_WIDTH-1:0] rd_index;
	logic                       ram_wr_en;
	logic                       ram_rd_en;
	logic [`AXI_DATA_WIDTH-1:0] ram_rd_data;

	// --------------------
	// pack / unpack
	// --------------------

	assign aw_in = '{id: s_axi4_awid, addr: s_axi4_awaddr,
		len: s_axi4_awlen, size: s_axi4_awsize};
	assign ar_in = '{id: s_axi4_arid, addr: s_axi4_araddr,
		len: s_axi4_arlen, size: s_axi4_arsize};
	assign w_beat = '{data: s_axi4_wdata, strb: s_axi4_wstrb, last: s_axi4_wlast};

	assign s_axi4_rid   = r_beat.id;
	assign s_axi4_rdata = r_beat.data;
	assign s_axi4_rlast = r_beat.last;

	// always okay
	assign s_axi4_bresp = 2'b00;
	assign s_axi4_rresp = 2'b00;

	// --------------------
	// blocks
	// --------------------

	req_fifo aw_fifo_i (
		.aclk    (aclk),
		.aresetn (aresetn),
		.s_req   (aw_in),
		.s_valid (s_axi4_awvalid),
		.s_ready (s_axi4_awready),
		.m_req   (aw_req),
		.m_valid (aw_req_valid),
		.m_ready (aw_req_ready)
	);

	req_fifo ar_fifo_i (
		.aclk    (aclk),
		.aresetn (aresetn),
		.s_req   (ar_in),
		.s_valid (s_axi4_arvalid),
		.s_ready (s_axi4_arready),
		.m_req   (ar_req),
		.m_valid (ar_req_valid),
		.m_ready (ar_req_ready)
	);

	axi_burst_ctrl ctrl_i (
		.aclk        (aclk),
		.aresetn     (aresetn),
		.aw_req      (aw_req),
		.aw_valid    (aw_req_valid),
		.aw_ready    (aw_req_ready),
		.w_beat      (w_beat),
		.w_valid     (s_axi4_wvalid),
		.w_ready     (s_axi4_wready),
		.b_id        (s_axi4_bid),
		.b_valid     (s_axi4_bvalid),
		.b_ready     (s_axi4_bready),
		.ar_req      (ar_req),
		.ar_valid    (ar_req_valid),
		.ar_ready    (ar_req_ready),
		.r_beat      (r_beat),
		.r_valid     (s_axi4_rvalid),
		.r_ready     (s_axi4_rready),
		.wr_load     (wr_load),
		.wr_step     (wr_step),
		.wr_last     (wr_last),
		.rd_load     (rd_load),
		.rd_step     (rd_step),
		.rd_last     (rd_last),
		.ram_wr_en   (ram_wr_en),
		.ram_rd_en   (ram_rd_en),
		.ram_rd_data (ram_rd_data)
	);

	burst_addr_gen wr_addr_i (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.load       (wr_load),
		.req        (aw_req),
		.step       (wr_step),
		.word_index (wr_index),
		.last       (wr_last)
	);

	burst_addr_gen rd_addr_i (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.load       (rd_load),
		.req        (ar_req),
		.step       (rd_step),
		.word_index (rd_index),
		.last       (rd_last)
	);

	byte_ram ram_i (
		.aclk     (aclk),
		.wr_en    (ram_wr_en),
		.wr_index (wr_index),
		.wr_strb  (w_beat.strb),
		.wr_data  (w_beat.data),
		.rd_en    (ram_rd_en),
		.rd_index (rd_index),
		.rd_data  (ram_rd_data)
	);

endmodule

`default_nettype wire

//--- hdl/axi_burst_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_cfg.svh"

module axi_burst_ctrl (
	input  logic                       aclk,
	input  logic                       aresetn,

	input  axi_mem_pkg::axi_req_t      aw_req,
	input  logic                       aw_valid,
	output logic                       aw_ready,

	input  axi_mem_pkg::w_beat_t       w_beat,
	input  logic                       w_valid,
	output logic                       w_ready,

	output logic [`AXI_ID_WIDTH-1:0]   b_id,
	output logic                       b_valid,
	input  logic                       b_ready,

	input  axi_mem_pkg::axi_req_t      ar_req,
	input  logic                       ar_valid,
	output logic                       ar_ready,

	output axi_mem_pkg::r_beat_t       r_beat,
	output logic                       r_valid,
	input  logic                       r_ready,

	output logic                       wr_load,
	output logic                       wr_step,
	input  logic                       wr_last,

	output logic                       rd_load,
	output logic                       rd_step,
	input  logic                       rd_last,

	output logic                       ram_wr_en,
	output logic                       ram_rd_en,
	input  logic [`AXI_DATA_WIDTH-1:0] ram_rd_data
);

	typedef enum logic [1:0] {
		W_IDLE,
		W_DATA,
		W_RESP
	} w_state_e;

	// --------------------
	// write path
	// --------------------

	w_state_e w_state;

	assign aw_ready  = (w_state == W_IDLE);
	assign wr_load   = aw_valid && aw_ready;
	assign w_ready   = (w_state == W_DATA);
	assign wr_step   = w_valid && w_ready;
	assign ram_wr_en = wr_step;
	assign b_valid   = (w_state == W_RESP);

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			w_state <= W_IDLE;
		end else begin
			case (w_state)
				W_IDLE: begin
					if (wr_load) begin
						w_state <= W_DATA;
					end
				end
				// beat count from the generator ends the burst
				W_DATA: begin
					if (wr_step && wr_last) begin
						w_state <= W_RESP;
					end
				end
				W_RESP: begin
					if (b_ready) begin
						w_state <= W_IDLE;
					end
				end
				default: begin
					w_state <= W_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (wr_load) begin
			b_id <= aw_req.id;
		end
	end

	// --------------------
	// read path
	// --------------------

	logic                     rd_active;
	logic [`AXI_ID_WIDTH-1:0] rd_id_q;

	// beat coming out of the ram this cycle
	logic                     ram_vld;
	logic [`AXI_ID_WIDTH-1:0] ram_id_q;
	logic                     ram_last_q;
	axi_mem_pkg::r_beat_t     ram_beat;

	axi_mem_pkg::r_beat_t     rbuf [2];
	logic                     buf_wr_ptr;
	logic                     buf_rd_ptr;
	logic [1:0]               buf_cnt;
	logic                     buf_push;
	logic                     buf_pop;
	logic [1:0]               in_flight;

	assign ar_ready = !rd_active;
	assign rd_load  = ar_valid && ar_ready;

	// issue only while the buffer can still take the beat
	assign in_flight = buf_cnt + {1'b0, ram_vld};
	assign ram_rd_en = rd_active && (in_flight < 2'd2);
	assign rd_step   = ram_rd_en;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			rd_active <= 1'b0;
			ram_vld   <= 1'b0;
		end else begin
			ram_vld <= ram_rd_en;
			if (rd_load) begin
				rd_active <= 1'b1;
			end else if (ram_rd_en && rd_last) begin
				rd_active <= 1'b0;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (rd_load) begin
			rd_id_q <= ar_req.id;
		end
		if (ram_rd_en) begin
			ram_id_q   <= rd_id_q;
			ram_last_q <= rd_last;
		end
	end

	assign ram_beat = '{id: ram_id_q, data: ram_rd_data, last: ram_last_q};

	// empty buffer with rready high lets the ram beat pass straight out
	assign buf_pop  = (buf_cnt != 2'd0) && r_ready;
	assign buf_push = ram_vld && !((buf_cnt == 2'd0) && r_ready);

	assign r_valid = (buf_cnt != 2'd0) || ram_vld;
	assign r_beat  = (buf_cnt != 2'd0) ? rbuf[buf_rd_ptr] : ram_beat;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			buf_wr_ptr <= 1'b0;
			buf_rd_ptr <= 1'b0;
			buf_cnt    <= 2'd0;
		end else begin
			if (buf_push) begin
				buf_wr_ptr <= !buf_wr_ptr;
			end
			if (buf_pop) begin
				buf_rd_ptr <= !buf_rd_ptr;
			end
			case ({buf_push, buf_pop})
				2'b10:   buf_cnt <= buf_cnt + 2'd1;
				2'b01:   buf_cnt <= buf_cnt - 2'd1;
				default: buf_cnt <= buf_cnt;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (buf_push) begin
			rbuf[buf_wr_ptr] <= ram_beat;
		end
	end

	// --------------------
	// checks
	// --------------------

	// master's wlast must agree with the burst length from aw
	a_wlast_match: assert property (@(posedge aclk) disable iff (!aresetn)
		(w_valid && w_ready) |-> (w_beat.last == wr_last));

	a_r_stable: assert property (@(posedge aclk) disable iff (!aresetn)
		(r_valid && !r_ready) |=> (r_valid && $stable(r_beat)));

endmodule

`default_nettype wire

//--- hdl/byte_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_cfg.svh"

module byte_ram (
	input  logic                       aclk,

	input  logic                       wr_en,
	input  logic [`MEM_ADDR_WIDTH-1:0] wr_index,
	input  logic [`AXI_STRB_WIDTH-1:0] wr_strb,
	input  logic [`AXI_DATA_WIDTH-1:0] wr_data,

	input  logic                       rd_en,
	input  logic [`MEM_ADDR_WIDTH-1:0] rd_index,
	output logic [`AXI_DATA_WIDTH-1:0] rd_data
);

	localparam int DEPTH = 1 << `MEM_ADDR_WIDTH;

	logic [`AXI_DATA_WIDTH-1:0] mem [DEPTH];

	// per-byte enables
	always_ff @(posedge aclk) begin
		if (wr_en) begin
			for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
				if (wr_strb[i]) begin
					mem[wr_index][i*8 +: 8] <= wr_data[i*8 +: 8];
				end
			end
		end
	end

	// one cycle read latency
	always_ff @(posedge aclk) begin
		if (rd_en) begin
			rd_data <= mem[rd_index];
		end
	end

endmodule

`default_nettype wire

//--- hdl/burst_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_cfg.svh"

module burst_addr_gen (
	input  logic                       aclk,
	input  logic                       aresetn,

	input  logic                       load,
	input  axi_mem_pkg::axi_req_t      req,
	input  logic                       step,

	output logic [`MEM_ADDR_WIDTH-1:0] word_index,
	output logic                       last
);

	localparam int AW = `AXI_ADDR_WIDTH;
	localparam int LW = `AXI_LEN_WIDTH;
	localparam int MW = `MEM_ADDR_WIDTH;

	logic [AW-1:0] addr_q;
	logic [LW-1:0] count_q;
	logic [2:0]    size_q;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			addr_q  <= '0;
			count_q <= '0;
			size_q  <= '0;
		end else if (load) begin
			addr_q  <= req.addr;
			count_q <= req.len;
			size_q  <= req.size;
		end else if (step) begin
			// incr only, narrow beats advance by their own size
			addr_q  <= addr_q + (AW'(1) << size_q);
			count_q <= count_q - LW'(1);
		end
	end

	// wraps modulo the memory depth
	assign word_index = MW'(addr_q >> `AXI_DATA_SIZE);
	assign last       = (count_q == '0);

endmodule

`default_nettype wire

//--- hdl/req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_cfg.svh"

module req_fifo (
	input  logic                  aclk,
	input  logic                  aresetn,

	input  axi_mem_pkg::axi_req_t s_req,
	input  logic                  s_valid,
	output logic                  s_ready,

	output axi_mem_pkg::axi_req_t m_req,
	output logic                  m_valid,
	input  logic                  m_ready
);

	localparam int PTR_W = `REQ_FIFO_PTR_WIDTH;
	localparam int DEPTH = 1 << PTR_W;

	axi_mem_pkg::axi_req_t mem [DEPTH];

	// extra msb tells full from empty
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic           full;
	logic           empty;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

	assign s_ready = !full;
	assign m_valid = !empty;
	assign m_req   = mem[rd_ptr[PTR_W-1:0]];

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (s_valid && s_ready) begin
				wr_ptr <= wr_ptr + (PTR_W+1)'(1);
			end
			if (m_valid && m_ready) begin
				rd_ptr <= rd_ptr + (PTR_W+1)'(1);
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (s_valid && s_ready) begin
			mem[wr_ptr[PTR_W-1:0]] <= s_req;
		end
	end

	// a request held off by a full queue stays offered and unchanged
	a_hold_when_full: assert property (@(posedge aclk) disable iff (!aresetn)
		(full && s_valid) |=> (s_valid && $stable(s_req)));

endmodule

`default_nettype wire

//--- hdl/axi_mem_pkg.sv
`default_nettype none

`include "axi_mem_cfg.svh"

package axi_mem_pkg;

	// one aw or ar request
	typedef struct packed {
		logic [`AXI_ID_WIDTH-1:0]   id;
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [`AXI_LEN_WIDTH-1:0]  len;
		logic [2:0]                 size;
	} axi_req_t;

	// one beat on the w channel
	typedef struct packed {
		logic [`AXI_DATA_WIDTH-1:0] data;
		logic [`AXI_STRB_WIDTH-1:0] strb;
		logic                       last;
	} w_beat_t;

	// one beat on the r channel
	typedef struct packed {
		logic [`AXI_ID_WIDTH-1:0]   id;
		logic [`AXI_DATA_WIDTH-1:0] data;
		logic                       last;
	} r_beat_t;

endpackage

`default_nettype wire

//--- include/axi_mem_cfg.svh
`ifndef AXI_MEM_CFG_SVH
`define AXI_MEM_CFG_SVH

// axi port widths
`define AXI_ID_WIDTH        4
`define AXI_ADDR_WIDTH      32
`define AXI_LEN_WIDTH       8

// log2 of the bus width in bytes
`define AXI_DATA_SIZE       2
`define AXI_DATA_WIDTH      (8 << `AXI_DATA_SIZE)
`define AXI_STRB_WIDTH      (1 << `AXI_DATA_SIZE)

// memory depth in words, as log2
`define MEM_ADDR_WIDTH      10

// request queue depth, as log2
`define REQ_FIFO_PTR_WIDTH  2

`endif
